//--- Makefile
TOP := rv_id_tb

.PHONY: all lint clean

all:
	verilator --binary --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/id_ctrl_pkg.sv
logic/imm_gen.sv
logic/id_decoder.sv
logic/reg_file.sv
logic/id_stage.sv
logic/rv_id_top.sv
verif/rv_id_props.sv
verif/rv_id_tb.sv

//--- logic/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

    typedef logic [1:0] op1_sel_t;
    typedef logic [2:0] op2_sel_t;
    typedef logic [1:0] base_sel_t;
    typedef logic [2:0] off_sel_t;

    // first execute operand
    localparam op1_sel_t OP1_ZERO = 2'd0;
    localparam op1_sel_t OP1_RS1  = 2'd1;
    localparam op1_sel_t OP1_PC   = 2'd2;

    // second execute operand
    localparam op2_sel_t OP2_ZERO   = 3'd0;
    localparam op2_sel_t OP2_RS2    = 3'd1;
    localparam op2_sel_t OP2_RS2_SH = 3'd2; // rs2 low bits as shift count
    localparam op2_sel_t OP2_IMM_I  = 3'd3;
    localparam op2_sel_t OP2_SHAMT  = 3'd4;
    localparam op2_sel_t OP2_IMM_U  = 3'd5;
    localparam op2_sel_t OP2_FOUR   = 3'd6; // link value for jumps

    // address base
    localparam base_sel_t BASE_ZERO = 2'd0;
    localparam base_sel_t BASE_RS1  = 2'd1;
    localparam base_sel_t BASE_PC   = 2'd2;

    // address offset
    localparam off_sel_t OFF_ZERO  = 3'd0;
    localparam off_sel_t OFF_IMM_I = 3'd1;
    localparam off_sel_t OFF_IMM_S = 3'd2;
    localparam off_sel_t OFF_IMM_B = 3'd3;
    localparam off_sel_t OFF_IMM_J = 3'd4;
    localparam off_sel_t OFF_IMM_U = 3'd5;

endpackage

`default_nettype wire

//--- logic/id_decoder.sv
`default_nettype none

module id_decoder (
    input  wire rv_isa_pkg::opcode_t   opcode_i,
    input  wire rv_isa_pkg::funct3_t   funct3_i,
    input  wire rv_isa_pkg::funct7_t   funct7_i,
    input  wire rv_isa_pkg::reg_addr_t rd_i,
    input  wire rv_isa_pkg::reg_addr_t rs1_i,
    input  wire rv_isa_pkg::reg_addr_t rs2_i,
    output rv_isa_pkg::reg_addr_t      rs1_addr_o,
    output rv_isa_pkg::reg_addr_t      rs2_addr_o,
    output rv_isa_pkg::reg_addr_t      rd_addr_o,
    output logic                       reg_wen_o,
    output id_ctrl_pkg::op1_sel_t      op1_sel_o,
    output id_ctrl_pkg::op2_sel_t      op2_sel_o,
    output id_ctrl_pkg::base_sel_t     base_sel_o,
    output id_ctrl_pkg::off_sel_t      off_sel_o
);

    logic use_rs1;
    logic use_rs2;
    logic shift_f3;

    assign shift_f3 = (funct3_i == rv_isa_pkg::F3_SLL) || (funct3_i == rv_isa_pkg::F3_SR);

    always_comb begin
        // unknown encodings fall through with everything zero
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        reg_wen_o  = 1'b0;
        op1_sel_o  = id_ctrl_pkg::OP1_ZERO;
        op2_sel_o  = id_ctrl_pkg::OP2_ZERO;
        base_sel_o = id_ctrl_pkg::BASE_ZERO;
        off_sel_o  = id_ctrl_pkg::OFF_ZERO;
        case (opcode_i)
            rv_isa_pkg::OPC_IMM, rv_isa_pkg::OPC_IMM_W: begin
                // W form only has ADDIW and the shifts
                if (opcode_i == rv_isa_pkg::OPC_IMM || funct3_i == rv_isa_pkg::F3_ADD ||
                    shift_f3) begin
                    use_rs1   = 1'b1;
                    reg_wen_o = 1'b1;
                    op1_sel_o = id_ctrl_pkg::OP1_RS1;
                    op2_sel_o = shift_f3 ? id_ctrl_pkg::OP2_SHAMT : id_ctrl_pkg::OP2_IMM_I;
                end
            end
            rv_isa_pkg::OPC_REG: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                reg_wen_o = 1'b1;
                op1_sel_o = id_ctrl_pkg::OP1_RS1;
                op2_sel_o = id_ctrl_pkg::OP2_RS2;
                // DIVU shares func3 101 with the right shifts
                if (funct3_i == rv_isa_pkg::F3_SLL ||
                    (funct3_i == rv_isa_pkg::F3_SR && funct7_i != rv_isa_pkg::F7_MULDIV)) begin
                    op2_sel_o = id_ctrl_pkg::OP2_RS2_SH;
                end
            end
            rv_isa_pkg::OPC_REG_W: begin
                // no SLT/SLTU in the W group
                if (funct3_i != rv_isa_pkg::F3_SLT && funct3_i != rv_isa_pkg::F3_SLTU) begin
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    reg_wen_o = 1'b1;
                    op1_sel_o = id_ctrl_pkg::OP1_RS1;
                    op2_sel_o = id_ctrl_pkg::OP2_RS2;   // full rs2 even for shifts
                end
            end
            rv_isa_pkg::OPC_BRANCH: begin
                case (funct3_i)
                    rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE, rv_isa_pkg::F3_BLT,
                    rv_isa_pkg::F3_BGE, rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU: begin
                        use_rs1    = 1'b1;
                        use_rs2    = 1'b1;
                        op1_sel_o  = id_ctrl_pkg::OP1_RS1;
                        op2_sel_o  = id_ctrl_pkg::OP2_RS2;
                        base_sel_o = id_ctrl_pkg::BASE_PC;
                        off_sel_o  = id_ctrl_pkg::OFF_IMM_B;
                    end
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_LOAD: begin
                if (funct3_i != 3'b111) begin       // only 111 is unused
                    use_rs1    = 1'b1;
                    reg_wen_o  = 1'b1;
                    op1_sel_o  = id_ctrl_pkg::OP1_RS1;
                    op2_sel_o  = id_ctrl_pkg::OP2_IMM_I;
                    base_sel_o = id_ctrl_pkg::BASE_RS1;
                    off_sel_o  = id_ctrl_pkg::OFF_IMM_I;
                end
            end
            rv_isa_pkg::OPC_STORE: begin
                case (funct3_i)
                    rv_isa_pkg::F3_SB, rv_isa_pkg::F3_SH,
                    rv_isa_pkg::F3_SW, rv_isa_pkg::F3_SD: begin
                        use_rs1    = 1'b1;
                        use_rs2    = 1'b1;
                        op2_sel_o  = id_ctrl_pkg::OP2_RS2;  // store data
                        base_sel_o = id_ctrl_pkg::BASE_RS1;
                        off_sel_o  = id_ctrl_pkg::OFF_IMM_S;
                    end
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
                // rd gets pc + 4
                reg_wen_o = 1'b1;
                op1_sel_o = id_ctrl_pkg::OP1_PC;
                op2_sel_o = id_ctrl_pkg::OP2_FOUR;
                if (opcode_i == rv_isa_pkg::OPC_JALR) begin
                    use_rs1    = 1'b1;
                    base_sel_o = id_ctrl_pkg::BASE_RS1;
                    off_sel_o  = id_ctrl_pkg::OFF_IMM_I;
                end else begin
                    base_sel_o = id_ctrl_pkg::BASE_PC;
                    off_sel_o  = id_ctrl_pkg::OFF_IMM_J;
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                reg_wen_o = 1'b1;
                op2_sel_o = id_ctrl_pkg::OP2_IMM_U;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                reg_wen_o = 1'b1;
                op1_sel_o = id_ctrl_pkg::OP1_PC;
                op2_sel_o = id_ctrl_pkg::OP2_IMM_U;
                off_sel_o = id_ctrl_pkg::OFF_IMM_U;
            end
            default: ;
        endcase
    end

    // unused fields go out as x0
    assign rs1_addr_o = use_rs1 ? rs1_i : '0;
    assign rs2_addr_o = use_rs2 ? rs2_i : '0;
    assign rd_addr_o  = reg_wen_o ? rd_i : '0;

endmodule

`default_nettype wire

//--- logic/id_stage.sv
`default_nettype none
`include "rv_params.svh"

module id_stage (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        inst_valid_i,
    input  wire rv_isa_pkg::inst_t     inst_i,
    input  wire rv_isa_pkg::xword_t    inst_addr_i,
    input  wire rv_isa_pkg::xword_t    rs1_data_i,
    input  wire rv_isa_pkg::xword_t    rs2_data_i,
    output rv_isa_pkg::reg_addr_t      rs1_addr_o,
    output rv_isa_pkg::reg_addr_t      rs2_addr_o,
    output logic                       ex_valid_o,
    output rv_isa_pkg::inst_t          ex_inst_o,
    output rv_isa_pkg::xword_t         ex_inst_addr_o,
    output rv_isa_pkg::xword_t         ex_op1_o,
    output rv_isa_pkg::xword_t         ex_op2_o,
    output rv_isa_pkg::reg_addr_t      ex_rd_addr_o,
    output logic                       ex_reg_wen_o,
    output rv_isa_pkg::xword_t         ex_base_addr_o,
    output rv_isa_pkg::xword_t         ex_offset_addr_o
);

    rv_isa_pkg::opcode_t    opcode;
    rv_isa_pkg::funct3_t    funct3;
    rv_isa_pkg::funct7_t    funct7;
    rv_isa_pkg::reg_addr_t  rd;
    rv_isa_pkg::reg_addr_t  rs1;
    rv_isa_pkg::reg_addr_t  rs2;
    rv_isa_pkg::xword_t     imm_i, imm_s, imm_b, imm_j, imm_u, shamt;
    rv_isa_pkg::reg_addr_t  dec_rd_addr;
    logic                   dec_reg_wen;
    id_ctrl_pkg::op1_sel_t  op1_sel;
    id_ctrl_pkg::op2_sel_t  op2_sel;
    id_ctrl_pkg::base_sel_t base_sel;
    id_ctrl_pkg::off_sel_t  off_sel;
    rv_isa_pkg::xword_t     op1, op2, base_addr, offset_addr;

    imm_gen i_imm_gen (
        .inst_i   (inst_i),
        .opcode_o (opcode),
        .funct3_o (funct3),
        .funct7_o (funct7),
        .rd_o     (rd),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .imm_i_o  (imm_i),
        .imm_s_o  (imm_s),
        .imm_b_o  (imm_b),
        .imm_j_o  (imm_j),
        .imm_u_o  (imm_u),
        .shamt_o  (shamt)
    );

    id_decoder i_id_decoder (
        .opcode_i   (opcode),
        .funct3_i   (funct3),
        .funct7_i   (funct7),
        .rd_i       (rd),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (dec_rd_addr),
        .reg_wen_o  (dec_reg_wen),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .base_sel_o (base_sel),
        .off_sel_o  (off_sel)
    );

    always_comb begin
        case (op1_sel)
            id_ctrl_pkg::OP1_RS1: op1 = rs1_data_i;
            id_ctrl_pkg::OP1_PC:  op1 = inst_addr_i;
            default:              op1 = '0;
        endcase
        case (op2_sel)
            id_ctrl_pkg::OP2_RS2:    op2 = rs2_data_i;
            id_ctrl_pkg::OP2_RS2_SH: op2 = rv_isa_pkg::xword_t'(rs2_data_i[`SHAMT_W-1:0]);
            id_ctrl_pkg::OP2_IMM_I:  op2 = imm_i;
            id_ctrl_pkg::OP2_SHAMT:  op2 = shamt;
            id_ctrl_pkg::OP2_IMM_U:  op2 = imm_u;
            id_ctrl_pkg::OP2_FOUR:   op2 = rv_isa_pkg::xword_t'(4);
            default:                 op2 = '0;
        endcase
        case (base_sel)
            id_ctrl_pkg::BASE_RS1: base_addr = rs1_data_i;
            id_ctrl_pkg::BASE_PC:  base_addr = inst_addr_i;
            default:               base_addr = '0;
        endcase
        case (off_sel)
            id_ctrl_pkg::OFF_IMM_I: offset_addr = imm_i;
            id_ctrl_pkg::OFF_IMM_S: offset_addr = imm_s;
            id_ctrl_pkg::OFF_IMM_B: offset_addr = imm_b;
            id_ctrl_pkg::OFF_IMM_J: offset_addr = imm_j;
            id_ctrl_pkg::OFF_IMM_U: offset_addr = imm_u;
            default:                offset_addr = '0;
        endcase
    end

    // decode-to-execute register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_valid_o       <= 1'b0;
            ex_reg_wen_o     <= 1'b0;
            ex_rd_addr_o     <= '0;
            ex_inst_o        <= '0;
            ex_inst_addr_o   <= '0;
            ex_op1_o         <= '0;
            ex_op2_o         <= '0;
            ex_base_addr_o   <= '0;
            ex_offset_addr_o <= '0;
        end else begin
            ex_valid_o   <= inst_valid_i;
            ex_reg_wen_o <= inst_valid_i & dec_reg_wen;
            // rd follows the write enable, so a bubble never names a target
            ex_rd_addr_o <= inst_valid_i ? dec_rd_addr : '0;
            if (inst_valid_i) begin   // payload holds across bubbles
                ex_inst_o        <= inst_i;
                ex_inst_addr_o   <= inst_addr_i;
                ex_op1_o         <= op1;
                ex_op2_o         <= op2;
                ex_base_addr_o   <= base_addr;
                ex_offset_addr_o <= offset_addr;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
`default_nettype none
`include "rv_params.svh"

module imm_gen (
    input  wire rv_isa_pkg::inst_t inst_i,
    output rv_isa_pkg::opcode_t    opcode_o,
    output rv_isa_pkg::funct3_t    funct3_o,
    output rv_isa_pkg::funct7_t    funct7_o,
    output rv_isa_pkg::reg_addr_t  rd_o,
    output rv_isa_pkg::reg_addr_t  rs1_o,
    output rv_isa_pkg::reg_addr_t  rs2_o,
    output rv_isa_pkg::xword_t     imm_i_o,
    output rv_isa_pkg::xword_t     imm_s_o,
    output rv_isa_pkg::xword_t     imm_b_o,
    output rv_isa_pkg::xword_t     imm_j_o,
    output rv_isa_pkg::xword_t     imm_u_o,
    output rv_isa_pkg::xword_t     shamt_o
);

    assign opcode_o = inst_i[6:0];
    assign rd_o     = inst_i[11:7];
    assign funct3_o = inst_i[14:12];
    assign rs1_o    = inst_i[19:15];
    assign rs2_o    = inst_i[24:20];
    assign funct7_o = inst_i[31:25];

    // all immediates sign-extend from bit 31
    assign imm_i_o = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s_o = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
    assign imm_j_o = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};
    assign imm_u_o = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    // shift count is unsigned, bit 25 included for RV64
    assign shamt_o = {{(`XLEN-`SHAMT_W){1'b0}}, inst_i[20 +: `SHAMT_W]};

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none
`include "rv_params.svh"

module reg_file (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  wire rv_isa_pkg::reg_addr_t rs2_addr_i,
    input  wire                        wen_i,
    input  wire rv_isa_pkg::reg_addr_t waddr_i,
    input  wire rv_isa_pkg::xword_t    wdata_i,
    output rv_isa_pkg::xword_t         rs1_data_o,
    output rv_isa_pkg::xword_t         rs2_data_o
);

    rv_isa_pkg::xword_t regs [`REG_NUM];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin  // x0 is read-only
            regs[waddr_i] <= wdata_i;
        end
    end

    // reads see only earlier edges, no write bypass
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- logic/rv_id_top.sv
`default_nettype none

module rv_id_top (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        inst_valid_i,
    input  wire rv_isa_pkg::inst_t     inst_i,
    input  wire rv_isa_pkg::xword_t    inst_addr_i,
    input  wire                        wb_wen_i,
    input  wire rv_isa_pkg::reg_addr_t wb_addr_i,
    input  wire rv_isa_pkg::xword_t    wb_data_i,
    output logic                       ex_valid_o,
    output rv_isa_pkg::inst_t          ex_inst_o,
    output rv_isa_pkg::xword_t         ex_inst_addr_o,
    output rv_isa_pkg::xword_t         ex_op1_o,
    output rv_isa_pkg::xword_t         ex_op2_o,
    output rv_isa_pkg::reg_addr_t      ex_rd_addr_o,
    output logic                       ex_reg_wen_o,
    output rv_isa_pkg::xword_t         ex_base_addr_o,
    output rv_isa_pkg::xword_t         ex_offset_addr_o
);

    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::xword_t    rs1_data;
    rv_isa_pkg::xword_t    rs2_data;

    id_stage i_id_stage (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .inst_valid_i     (inst_valid_i),
        .inst_i           (inst_i),
        .inst_addr_i      (inst_addr_i),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .ex_valid_o       (ex_valid_o),
        .ex_inst_o        (ex_inst_o),
        .ex_inst_addr_o   (ex_inst_addr_o),
        .ex_op1_o         (ex_op1_o),
        .ex_op2_o         (ex_op2_o),
        .ex_rd_addr_o     (ex_rd_addr_o),
        .ex_reg_wen_o     (ex_reg_wen_o),
        .ex_base_addr_o   (ex_base_addr_o),
        .ex_offset_addr_o (ex_offset_addr_o)
    );

    // writeback comes straight from outside
    reg_file i_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wen_i      (wb_wen_i),
        .waddr_i    (wb_addr_i),
        .wdata_i    (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

endmodule

`default_nettype wire

//--- logic/rv_isa_pkg.sv
`default_nettype none
`include "rv_params.svh"

package rv_isa_pkg;

    typedef logic [31:0]            inst_t;
    typedef logic [`XLEN-1:0]       xword_t;    // register value or address
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]             opcode_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [6:0]             funct7_t;

    // major opcodes of the kept groups
    localparam opcode_t OPC_IMM    = 7'b0010011;
    localparam opcode_t OPC_IMM_W  = 7'b0011011;
    localparam opcode_t OPC_REG    = 7'b0110011; // also M extension
    localparam opcode_t OPC_REG_W  = 7'b0111011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // arithmetic and shift codes
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_SR   = 3'b101; // SRL/SRA, DIVU with muldiv func7

    // branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // loads
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_LWU = 3'b110;

    // stores
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;
    localparam funct3_t F3_SD = 3'b011;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000; // SUB, SRA
    localparam funct7_t F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

//--- logic/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath width
`define XLEN       64

// integer register file
`define REG_NUM    32
`define REG_ADDR_W 5

// RV64 shift amounts are 6 bits wide
`define SHAMT_W    6

`endif

//--- verif/rv_id_props.sv
`default_nettype none

module rv_id_props (
    input wire                        clk_i,
    input wire                        rst_i,
    input wire                        ex_valid_i,
    input wire                        ex_reg_wen_i,
    input wire rv_isa_pkg::reg_addr_t ex_rd_addr_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // a register write only comes with a live instruction
    wen_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        ex_reg_wen_i |-> ex_valid_i)
        else $error("ex_reg_wen_o high while ex_valid_o is low");

    valid_low_after_reset: assert property (@(posedge clk_i)
        $past(rst_i) |-> !ex_valid_i)
        else $error("ex_valid_o high in the cycle after reset");

    rd_zero_without_wen: assert property (@(posedge clk_i) disable iff (rst_i)
        !ex_reg_wen_i |-> (ex_rd_addr_i == '0))     // bubbles and stores name no target
        else $error("ex_rd_addr_o nonzero while ex_reg_wen_o is low");

endmodule

bind rv_id_top rv_id_props i_rv_id_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ex_valid_i   (ex_valid_o),
    .ex_reg_wen_i (ex_reg_wen_o),
    .ex_rd_addr_i (ex_rd_addr_o)
);

`default_nettype wire

//--- verif/rv_id_tb.sv
`default_nettype none
`include "rv_params.svh"

module rv_id_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INST     = 400;
    localparam int TIMEOUT_NS = (4 + `REG_NUM + N_INST + 6) * 20 * 2;   // double the run length

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::inst_t     inst;
        rv_isa_pkg::xword_t    addr;
        rv_isa_pkg::xword_t    op1;
        rv_isa_pkg::xword_t    op2;
        rv_isa_pkg::reg_addr_t rd;
        logic                  wen;
        rv_isa_pkg::xword_t    base;
        rv_isa_pkg::xword_t    offset;
    } exp_t;

    logic                  clk;
    logic                  rst;
    logic                  inst_valid;
    rv_isa_pkg::inst_t     inst;
    rv_isa_pkg::xword_t    inst_addr;
    logic                  wb_wen;
    rv_isa_pkg::reg_addr_t wb_addr;
    rv_isa_pkg::xword_t    wb_data;
    logic                  ex_valid;
    rv_isa_pkg::inst_t     ex_inst;
    rv_isa_pkg::xword_t    ex_inst_addr;
    rv_isa_pkg::xword_t    ex_op1;
    rv_isa_pkg::xword_t    ex_op2;
    rv_isa_pkg::reg_addr_t ex_rd_addr;
    logic                  ex_reg_wen;
    rv_isa_pkg::xword_t    ex_base_addr;
    rv_isa_pkg::xword_t    ex_offset_addr;

    rv_isa_pkg::xword_t mirror [`REG_NUM];  // what the register file should hold
    exp_t               exp_q [$];
    exp_t               last_exp;
    int                 n_pushed;
    int                 n_checked;

    rv_id_top i_rv_id_top (
        .clk_i            (clk),
        .rst_i            (rst),
        .inst_valid_i     (inst_valid),
        .inst_i           (inst),
        .inst_addr_i      (inst_addr),
        .wb_wen_i         (wb_wen),
        .wb_addr_i        (wb_addr),
        .wb_data_i        (wb_data),
        .ex_valid_o       (ex_valid),
        .ex_inst_o        (ex_inst),
        .ex_inst_addr_o   (ex_inst_addr),
        .ex_op1_o         (ex_op1),
        .ex_op2_o         (ex_op2),
        .ex_rd_addr_o     (ex_rd_addr),
        .ex_reg_wen_o     (ex_reg_wen),
        .ex_base_addr_o   (ex_base_addr),
        .ex_offset_addr_o (ex_offset_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected decode result, built straight from the ISA field layout
    function automatic exp_t decode_model(input logic v, input rv_isa_pkg::inst_t w,
                                          input rv_isa_pkg::xword_t pc, input exp_t prev);
        exp_t                e;
        rv_isa_pkg::xword_t  r1, r2, imm_i, imm_s, imm_b, imm_j, imm_u, shamt;
        rv_isa_pkg::opcode_t opc;
        rv_isa_pkg::funct3_t f3;
        if (!v) begin
            e = prev;           // bubble keeps the payload
            e.valid = 1'b0;
            e.wen = 1'b0;
            e.rd = '0;
            return e;
        end
        opc = w[6:0];
        f3 = w[14:12];
        r1 = mirror[w[19:15]];
        r2 = mirror[w[24:20]];
        imm_i = $signed({w[31:20], 52'b0}) >>> 52;
        imm_s = $signed({w[31:25], w[11:7], 52'b0}) >>> 52;
        imm_b = $signed({w[31], w[7], w[30:25], w[11:8], 52'b0}) >>> 51;
        imm_j = $signed({w[31], w[19:12], w[20], w[30:21], 44'b0}) >>> 43;
        imm_u = $signed({w[31:12], 44'b0}) >>> 32;
        shamt = {58'b0, w[25:20]};
        e = '0;
        e.valid = 1'b1;
        e.inst = w;
        e.addr = pc;
        case (opc)
            rv_isa_pkg::OPC_IMM, rv_isa_pkg::OPC_IMM_W: begin
                if (opc == rv_isa_pkg::OPC_IMM || f3 inside {3'b000, 3'b001, 3'b101}) begin
                    e.op1 = r1;
                    e.op2 = (f3 == 3'b001 || f3 == 3'b101) ? shamt : imm_i;
                    e.wen = 1'b1;
                end
            end
            rv_isa_pkg::OPC_REG: begin
                e.op1 = r1;
                e.op2 = (f3 == 3'b001 || (f3 == 3'b101 && w[31:25] != rv_isa_pkg::F7_MULDIV))
                        ? {58'b0, r2[5:0]} : r2;
                e.wen = 1'b1;
            end
            rv_isa_pkg::OPC_REG_W: begin
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    e.op1 = r1;
                    e.op2 = r2;
                    e.wen = 1'b1;
                end
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    e.op1 = r1;
                    e.op2 = r2;
                    e.base = pc;
                    e.offset = imm_b;
                end
            end
            rv_isa_pkg::OPC_LOAD: begin
                if (f3 != 3'b111) begin
                    e.op1 = r1;
                    e.op2 = imm_i;
                    e.base = r1;
                    e.offset = imm_i;
                    e.wen = 1'b1;
                end
            end
            rv_isa_pkg::OPC_STORE: begin
                if (!f3[2]) begin   // SB..SD only
                    e.op2 = r2;
                    e.base = r1;
                    e.offset = imm_s;
                end
            end
            rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
                e.op1 = pc;
                e.op2 = 64'd4;
                e.base = (opc == rv_isa_pkg::OPC_JAL) ? pc : r1;
                e.offset = (opc == rv_isa_pkg::OPC_JAL) ? imm_j : imm_i;
                e.wen = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                e.op2 = imm_u;
                e.wen = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                e.op1 = pc;
                e.op2 = imm_u;
                e.offset = imm_u;
                e.wen = 1'b1;
            end
            default: ;
        endcase
        e.rd = e.wen ? w[11:7] : '0;
        return e;
    endfunction

    function automatic rv_isa_pkg::inst_t random_inst();
        rv_isa_pkg::inst_t w;
        int                pick;
        w = $urandom;
        pick = int'($urandom % 12);
        case (pick)
            0:  w[6:0] = rv_isa_pkg::OPC_IMM;
            1:  w[6:0] = rv_isa_pkg::OPC_IMM_W;
            2:  w[6:0] = rv_isa_pkg::OPC_REG;
            3:  w[6:0] = rv_isa_pkg::OPC_REG_W;
            4:  w[6:0] = rv_isa_pkg::OPC_BRANCH;
            5:  w[6:0] = rv_isa_pkg::OPC_LOAD;
            6:  w[6:0] = rv_isa_pkg::OPC_STORE;
            7:  w[6:0] = rv_isa_pkg::OPC_JAL;
            8:  w[6:0] = rv_isa_pkg::OPC_JALR;
            9:  w[6:0] = rv_isa_pkg::OPC_LUI;
            10: w[6:0] = rv_isa_pkg::OPC_AUIPC;
            default: begin
                case ($urandom % 3)     // system, fence, all zero
                    0: w[6:0] = 7'b1110011;
                    1: w[6:0] = 7'b0001111;
                    default: w[6:0] = 7'b0000000;
                endcase
            end
        endcase
        if (pick == 2 || pick == 3) begin
            case ($urandom % 4)
                0: w[31:25] = rv_isa_pkg::F7_BASE;
                1: w[31:25] = rv_isa_pkg::F7_ALT;
                2: w[31:25] = rv_isa_pkg::F7_MULDIV;
                default: ;
            endcase
        end
        if ($urandom % 8 == 0) w[19:15] = '0;   // extra x0 reads
        if ($urandom % 8 == 0) w[24:20] = '0;
        return w;
    endfunction

    task automatic release_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        exp_q.push_back(last_exp);      // reset state, all zero
        n_pushed++;
    endtask

    task automatic drive_cycle(input logic v, input rv_isa_pkg::inst_t w,
                               input rv_isa_pkg::xword_t pc, input logic we,
                               input rv_isa_pkg::reg_addr_t wa, input rv_isa_pkg::xword_t wd);
        exp_t e;
        @(posedge clk);
        inst_valid <= v;
        inst <= w;
        inst_addr <= pc;
        wb_wen <= we;
        wb_addr <= wa;
        wb_data <= wd;
        e = decode_model(v, w, pc, last_exp);
        exp_q.push_back(e);
        last_exp = e;
        n_pushed++;
        if (we && wa != '0) mirror[wa] = wd;    // no bypass, seen from the next instruction
    endtask

    task automatic check_value(input string name, input rv_isa_pkg::xword_t got,
                               input rv_isa_pkg::xword_t expected);
        if (got !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    initial begin
        logic                  v;
        logic                  we;
        rv_isa_pkg::reg_addr_t wa;
        rv_isa_pkg::xword_t    pc;
        void'($urandom(65811));
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        inst_addr = '0;
        wb_wen = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        last_exp = '0;
        n_pushed = 0;
        n_checked = 0;
        for (int i = 0; i < `REG_NUM; i++) begin
            mirror[i] = '0;
        end
        release_reset();
        // preload, the x0 write must be dropped
        for (int i = 0; i < `REG_NUM; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, rv_isa_pkg::reg_addr_t'(i), {$urandom, $urandom});
        end
        // divu keeps full rs2 where srl takes its low bits
        drive_cycle(1'b1, {rv_isa_pkg::F7_MULDIV, 5'd7, 5'd3, rv_isa_pkg::F3_SR, 5'd9,
                           rv_isa_pkg::OPC_REG}, 64'h1000, 1'b0, '0, '0);
        drive_cycle(1'b1, {rv_isa_pkg::F7_BASE, 5'd7, 5'd3, rv_isa_pkg::F3_SR, 5'd9,
                           rv_isa_pkg::OPC_REG}, 64'h1004, 1'b0, '0, '0);
        for (int n = 0; n < N_INST; n++) begin
            v = ($urandom % 6 != 0);
            we = ($urandom % 8 == 0);
            wa = rv_isa_pkg::reg_addr_t'($urandom % 32);
            pc = {$urandom, $urandom} & ~64'h3;
            drive_cycle(v, random_inst(), pc, we, wa, {$urandom, $urandom});
        end
        drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
        drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
        repeat (2) @(negedge clk);
        if (n_checked == n_pushed - 1) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "only %0d of %0d results were compared", n_checked, n_pushed - 1);
        end
    end

    // outputs settle after the edge, compare half a cycle later
    initial begin
        exp_t e;
        forever begin
            @(negedge clk);
            if (exp_q.size() > 1) begin
                e = exp_q.pop_front();
                check_value("ex_valid_o", {63'b0, ex_valid}, {63'b0, e.valid});
                check_value("ex_reg_wen_o", {63'b0, ex_reg_wen}, {63'b0, e.wen});
                check_value("ex_rd_addr_o", {59'b0, ex_rd_addr}, {59'b0, e.rd});
                check_value("ex_inst_o", {32'b0, ex_inst}, {32'b0, e.inst});
                check_value("ex_inst_addr_o", ex_inst_addr, e.addr);
                check_value("ex_op1_o", ex_op1, e.op1);
                check_value("ex_op2_o", ex_op2, e.op2);
                check_value("ex_base_addr_o", ex_base_addr, e.base);
                check_value("ex_offset_addr_o", ex_offset_addr, e.offset);
                n_checked++;
            end
        end
    end

    initial begin
        #TIMEOUT_NS;
        $display("Errors found");
        $fatal(1, "watchdog timeout, the run did not finish within %0d ns", TIMEOUT_NS);
    end

endmodule

`default_nettype wire
